// File: common/dram_req_if.sv
`timescale 1ns/100ps

interface dram_req_if #(
    parameter int LINE_BYTES = 16
);
    import ic_pkg::*;

    localparam int OFF_W = $clog2(LINE_BYTES);

    // Plain strobes, a request is accepted in any cycle where one is high
    logic    rd_en;
    logic    wr_en;
    addr_t   addr;
    funct3_t ctrl;

    // Byte position of the access inside one DRAM line
    logic [OFF_W-1:0] offset;

    assign offset = addr[OFF_W-1:0];

    modport decoder (
        output rd_en,
        output wr_en,
        output addr,
        output ctrl
    );

    modport aligner (
        input rd_en,
        input wr_en,
        input offset,
        input ctrl
    );

endinterface

// File: common/ic_pkg.sv
package ic_pkg;

    // CPU physical address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // One DRAM line, four words wide
    typedef logic [127:0] line_t;

    // Top address nibble selects the target device
    typedef logic [3:0] dev_t;

    // Load/store width code
    // Bits 1:0 give byte, half or word, bit 2 marks an unsigned load
    typedef logic [2:0] funct3_t;

    // Where the load data of the previous cycle comes from
    typedef enum logic [2:0] {
        RESP_NONE  = 3'd0,
        RESP_DRAM  = 3'd1,
        RESP_PLIC  = 3'd2,
        RESP_CLINT = 3'd3,
        RESP_FB    = 3'd4
    } resp_src_t;

    // Device nibbles, address bits 31:28
    localparam dev_t DEV_DRAM_LOW  = 4'h0;
    localparam dev_t DEV_VIRTIO    = 4'h4;
    localparam dev_t DEV_PLIC      = 4'h5;
    localparam dev_t DEV_CLINT     = 4'h6;
    localparam dev_t DEV_DRAM_BASE = 4'h8;

    // Sub-device nibble inside the VirtIO window, address bits 27:24
    localparam dev_t VIRT_FB = 4'h5;

    // DRAM sees only the low 27 address bits
    localparam addr_t DRAM_OFFSET_MASK = 32'h07ff_ffff;

    // Size field of the width code
    localparam logic [1:0] LS_BYTE = 2'd0;
    localparam logic [1:0] LS_HALF = 2'd1;

    // Position of the unsigned flag in the width code
    localparam int FUNCT3_UNSIGNED_BIT = 2;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu_mem_interconnect \
    -f verilog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: verif/cpu_mem_interconnect_assert.sv
`timescale 1ns/100ps

module cpu_mem_interconnect_assert (
    input logic          CLK,
    input logic          reset,
    input ic_pkg::addr_t cpu_addr,
    input logic          dram_busy,
    input logic          rd_en,
    input logic          wr_en,
    input logic          plic_we,
    input logic          plic_re,
    input logic          clint_we,
    input logic          fb_we
);
    import ic_pkg::*;

    dev_t dev;
    dev_t virt;

    assign dev  = cpu_addr[31:28];
    assign virt = cpu_addr[27:24];

    no_dram_strobe_when_busy: assert property (@(posedge CLK) disable iff (reset)
        dram_busy |-> !(rd_en || wr_en))
        else $error("DRAM strobe raised while DRAM is busy");

    dram_rd_wr_exclusive: assert property (@(posedge CLK) disable iff (reset)
        !(rd_en && wr_en))
        else $error("DRAM read and write strobes high together");

    // Peripheral strobes only inside their own window
    plic_strobe_in_window: assert property (@(posedge CLK) disable iff (reset)
        (plic_we || plic_re) |-> (dev == DEV_PLIC))
        else $error("PLIC strobe outside the PLIC window");

    clint_strobe_in_window: assert property (@(posedge CLK) disable iff (reset)
        clint_we |-> (dev == DEV_CLINT))
        else $error("CLINT strobe outside the CLINT window");

    fb_strobe_in_window: assert property (@(posedge CLK) disable iff (reset)
        fb_we |-> (dev == DEV_VIRTIO && virt == VIRT_FB))
        else $error("Framebuffer strobe outside the framebuffer window");

endmodule

bind mem_map_decode cpu_mem_interconnect_assert u_decode_assert (
    .CLK       (CLK),
    .reset     (reset),
    .cpu_addr  (cpu_addr),
    .dram_busy (dram_busy),
    .rd_en     (req.rd_en),
    .wr_en     (req.wr_en),
    .plic_we   (plic_we),
    .plic_re   (plic_re),
    .clint_we  (clint_we),
    .fb_we     (fb_we)
);

// File: verif/tb_cpu_mem_interconnect.sv
`timescale 1ns/100ps

module tb_cpu_mem_interconnect;
    import ic_pkg::*;

    localparam int N_TEST_CYCLES = 460;
    localparam int TIMEOUT_NS    = N_TEST_CYCLES * 10 + 2000;

    logic    CLK;
    logic    reset;
    addr_t   cpu_addr;
    data_t   cpu_wdata;
    funct3_t cpu_ctrl;
    logic    cpu_we;
    logic    cpu_re;
    logic    dram_busy;
    line_t   dram_rdata = '0;
    data_t   plic_rdata;
    data_t   clint_rdata;
    data_t   fb_rdata;
    logic    dram_rd_en;
    logic    dram_wr_en;
    addr_t   dram_addr;
    data_t   dram_wdata;
    funct3_t dram_ctrl;
    logic    plic_we;
    logic    plic_re;
    logic    clint_we;
    logic    fb_we;
    data_t   periph_wdata;
    data_t   load_data;
    logic    load_is_dram;

    integer seed = 32'hd952997a;

    // DRAM model holds 64 lines selected by address bits 9:4
    line_t mem [64];

    // Request seen at the last rising edge
    addr_t   prev_addr;
    funct3_t prev_ctrl;
    logic    prev_re;
    logic    prev_we;
    logic    prev_busy;
    line_t   prev_line;

    cpu_mem_interconnect u_cpu_mem_interconnect (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic line_t fill_line(input int idx);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = (idx * 4 + k) * 32'h9e37_79b9 ^ 32'h5a5a_0f0f;
        end
        return l;
    endfunction

    // Expected {load_is_dram, load_data} for the request of the previous cycle
    function automatic logic [32:0] expected_load(input logic re, input logic we,
                                                  input logic busy, input addr_t addr,
                                                  input funct3_t ctrl, input line_t line);
        logic [3:0]   dev;
        logic [127:0] sh;
        logic [31:0]  raw;
        logic [31:0]  word;
        dev = addr[31:28];
        if (!re || we) begin
            return 33'd0;
        end
        if (dev == 4'h0 || dev == 4'h8) begin
            if (busy) begin
                return 33'd0;
            end
            sh  = line >> {addr[3:0], 3'b000};
            raw = sh[31:0];
            case (ctrl[1:0])
                2'd0: word = ctrl[2] ? {24'h0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
                2'd1: word = ctrl[2] ? {16'h0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
                default: word = raw;
            endcase
            return {1'b1, word};
        end
        if (dev == 4'h5) return {1'b0, plic_rdata};
        if (dev == 4'h6) return {1'b0, clint_rdata};
        if (dev == 4'h4 && addr[27:24] == 4'h5) return {1'b0, fb_rdata};
        return 33'd0;
    endfunction

    function automatic addr_t rand_dram_addr();
        addr_t a;
        a = $random(seed);
        a[31:28] = a[31] ? 4'h8 : 4'h0;
        return a;
    endfunction

    // Byte, half or word, signed or unsigned
    function automatic funct3_t rand_load_ctrl();
        logic [31:0] r;
        r = $random(seed);
        if (r[1:0] == 2'd3) begin
            r[1:0] = 2'd2;
        end
        return {r[2], r[1:0]};
    endfunction

    task automatic fail_now(input string what);
        $display("FAIL %0t: %s", $time, what);
        $display("Checks failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic drive_cycle(input addr_t addr, input funct3_t ctrl, input logic re,
                               input logic we, input data_t wdata, input logic busy);
        @(posedge CLK);
        #1;
        cpu_addr  = addr;
        cpu_ctrl  = ctrl;
        cpu_re    = re;
        cpu_we    = we;
        cpu_wdata = wdata;
        dram_busy = busy;
    endtask

    task automatic drive_idle();
        drive_cycle(32'h0, 3'b010, 1'b0, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic write_then_read(input addr_t addr, input data_t data);
        drive_cycle(addr, 3'b010, 1'b0, 1'b1, data, 1'b0);
        drive_cycle(addr, 3'b010, 1'b1, 1'b0, 32'h0, 1'b0);
        drive_idle();
        @(negedge CLK);
        assert (load_data === data && load_is_dram === 1'b1)
            else fail_now($sformatf("read back %h from %h, wrote %h", load_data, addr, data));
    endtask

    // DRAM model returns the line one cycle after the read strobe
    always @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                mem[i] <= fill_line(i);
            end
            dram_rdata <= '0;
        end else begin
            if (dram_rd_en) begin
                dram_rdata <= mem[dram_addr[9:4]];
            end
            if (dram_wr_en) begin
                mem[dram_addr[9:4]][{dram_addr[3:2], 5'b00000} +: 32] <= dram_wdata;
            end
        end
    end

    always @(posedge CLK) begin
        if (reset) begin
            prev_re <= 1'b0;
            prev_we <= 1'b0;
        end else begin
            prev_addr <= cpu_addr;
            prev_ctrl <= cpu_ctrl;
            prev_re   <= cpu_re;
            prev_we   <= cpu_we;
            prev_busy <= dram_busy;
            prev_line <= mem[cpu_addr[9:4]];
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge CLK) begin
        logic [32:0] exp_load;
        logic [5:0]  exp_strb;
        logic [3:0]  dev;
        logic        dram_dev;
        if (!reset) begin
            dev      = cpu_addr[31:28];
            dram_dev = (dev == 4'h0) || (dev == 4'h8);
            exp_strb = {cpu_we && dram_dev && !dram_busy,
                        cpu_re && !cpu_we && dram_dev && !dram_busy,
                        cpu_we && dev == 4'h5,
                        cpu_re && dev == 4'h5,
                        cpu_we && dev == 4'h6,
                        cpu_we && dev == 4'h4 && cpu_addr[27:24] == 4'h5};
            exp_load = expected_load(prev_re, prev_we, prev_busy, prev_addr, prev_ctrl,
                                     prev_line);
            assert ({dram_wr_en, dram_rd_en, plic_we, plic_re, clint_we, fb_we} === exp_strb)
                else fail_now($sformatf("strobes %b for %h, expected %b",
                    {dram_wr_en, dram_rd_en, plic_we, plic_re, clint_we, fb_we},
                    cpu_addr, exp_strb));
            assert (dram_addr === (cpu_addr & 32'h07ff_ffff))
                else fail_now($sformatf("dram_addr %h for %h", dram_addr, cpu_addr));
            assert (dram_wdata === cpu_wdata && periph_wdata === cpu_wdata
                    && dram_ctrl === cpu_ctrl)
                else fail_now("write data or width code not passed through");
            assert ({load_is_dram, load_data} === exp_load)
                else fail_now($sformatf("load %b/%h after %h ctrl %b, expected %b/%h",
                    load_is_dram, load_data, prev_addr, prev_ctrl, exp_load[32],
                    exp_load[31:0]));
        end
    end

    initial begin
        logic [31:0] r;
        addr_t       a;
        reset       = 1'b1;
        // A PLIC load held through reset must leave no response behind
        cpu_addr    = 32'h5000_0010;
        cpu_wdata   = '0;
        cpu_ctrl    = 3'b010;
        cpu_we      = 1'b0;
        cpu_re      = 1'b1;
        dram_busy   = 1'b0;
        plic_rdata  = $random(seed);
        clint_rdata = $random(seed);
        fb_rdata    = $random(seed);
        repeat (8) @(posedge CLK);
        #1;
        reset    = 1'b0;
        cpu_addr = '0;
        cpu_re   = 1'b0;
        @(negedge CLK);
        assert (load_data === 32'h0 && load_is_dram === 1'b0 && !dram_rd_en && !dram_wr_en
                && !plic_we && !plic_re && !clint_we && !fb_we)
            else fail_now("outputs not idle after reset");

        for (int i = 0; i < 80; i++) begin
            drive_cycle(rand_dram_addr(), rand_load_ctrl(), 1'b1, 1'b0, 32'h0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            a = rand_dram_addr();
            write_then_read({a[31:2], 2'b00}, $random(seed));
        end

        // Peripheral reads and writes, then unmapped space
        drive_cycle(32'h5000_0010, 3'b010, 1'b1, 1'b0, 32'h0, 1'b0);
        drive_cycle(32'h6000_bff8, 3'b010, 1'b1, 1'b0, 32'h0, 1'b0);
        drive_cycle(32'h4500_0100, 3'b010, 1'b1, 1'b0, 32'h0, 1'b0);
        drive_cycle(32'h5000_0020, 3'b010, 1'b0, 1'b1, $random(seed), 1'b0);
        drive_cycle(32'h6000_4000, 3'b010, 1'b0, 1'b1, $random(seed), 1'b0);
        drive_cycle(32'h4500_0200, 3'b010, 1'b0, 1'b1, $random(seed), 1'b0);
        drive_cycle(32'h5000_0030, 3'b010, 1'b1, 1'b1, $random(seed), 1'b0);
        drive_cycle(32'h4100_0000, 3'b010, 1'b1, 1'b0, 32'h0, 1'b0);
        drive_cycle(32'h2000_0000, 3'b010, 1'b1, 1'b0, 32'h0, 1'b0);
        drive_cycle(32'hf000_0004, 3'b010, 1'b1, 1'b0, 32'h0, 1'b0);

        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            drive_cycle(rand_dram_addr(), rand_load_ctrl(), r[0], r[1], $random(seed), 1'b1);
        end

        // One request per cycle over every target
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            a = $random(seed);
            if (r[4]) begin
                a[31:28] = r[5] ? 4'h8 : 4'h0;
            end
            if (a[31:28] == 4'h4 && r[6]) begin
                a[27:24] = 4'h5;
            end
            drive_cycle(a, rand_load_ctrl(), r[0], r[1] & r[2], $random(seed),
                        r[9:8] == 2'd0);
        end
        repeat (3) drive_idle();
        @(negedge CLK);
        $display("All checks passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run went past its expected length");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verilog.f
common/ic_pkg.sv
common/dram_req_if.sv
verilog/mem_map_decode.sv
verilog/dram_load_align.sv
verilog/read_return_mux.sv
verilog/cpu_mem_interconnect.sv
verif/cpu_mem_interconnect_assert.sv
verif/tb_cpu_mem_interconnect.sv

// File: verilog/cpu_mem_interconnect.sv
`timescale 1ns/100ps

module cpu_mem_interconnect #(
    parameter int LINE_BYTES = 16
) (
    input  logic            CLK,
    input  logic            reset,
    // CPU side
    input  ic_pkg::addr_t   cpu_addr,
    input  ic_pkg::data_t   cpu_wdata,
    input  ic_pkg::funct3_t cpu_ctrl,
    input  logic            cpu_we,
    input  logic            cpu_re,
    // DRAM controller
    input  logic            dram_busy,
    input  ic_pkg::line_t   dram_rdata,
    // Peripheral read data
    input  ic_pkg::data_t   plic_rdata,
    input  ic_pkg::data_t   clint_rdata,
    input  ic_pkg::data_t   fb_rdata,
    // DRAM request
    output logic            dram_rd_en,
    output logic            dram_wr_en,
    output ic_pkg::addr_t   dram_addr,
    output ic_pkg::data_t   dram_wdata,
    output ic_pkg::funct3_t dram_ctrl,
    // Peripheral strobes
    output logic            plic_we,
    output logic            plic_re,
    output logic            clint_we,
    output logic            fb_we,
    output ic_pkg::data_t   periph_wdata,
    // Load return
    output ic_pkg::data_t   load_data,
    output logic            load_is_dram
);
    import ic_pkg::*;

    resp_src_t resp_src;
    data_t     dram_word;

    dram_req_if #(
        .LINE_BYTES(LINE_BYTES)
    ) dram_req ();

    mem_map_decode u_mem_map_decode (
        .CLK          (CLK),
        .reset        (reset),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_ctrl     (cpu_ctrl),
        .cpu_we       (cpu_we),
        .cpu_re       (cpu_re),
        .dram_busy    (dram_busy),
        .dram_addr    (dram_addr),
        .dram_wdata   (dram_wdata),
        .dram_ctrl    (dram_ctrl),
        .plic_we      (plic_we),
        .plic_re      (plic_re),
        .clint_we     (clint_we),
        .fb_we        (fb_we),
        .periph_wdata (periph_wdata),
        .resp_src     (resp_src),
        .req          (dram_req.decoder)
    );

    dram_load_align #(
        .LINE_BYTES(LINE_BYTES)
    ) u_dram_load_align (
        .CLK        (CLK),
        .reset      (reset),
        .dram_rdata (dram_rdata),
        .req        (dram_req.aligner),
        .dram_word  (dram_word)
    );

    read_return_mux u_read_return_mux (
        .resp_src     (resp_src),
        .dram_word    (dram_word),
        .plic_rdata   (plic_rdata),
        .clint_rdata  (clint_rdata),
        .fb_rdata     (fb_rdata),
        .load_data    (load_data),
        .load_is_dram (load_is_dram)
    );

    // DRAM strobes leave straight from the request interface
    assign dram_rd_en = dram_req.rd_en;
    assign dram_wr_en = dram_req.wr_en;

endmodule

// File: verilog/dram_load_align.sv
`timescale 1ns/100ps

module dram_load_align #(
    parameter int LINE_BYTES = 16
) (
    input  logic          CLK,
    input  logic          reset,
    input  ic_pkg::line_t dram_rdata,
    dram_req_if.aligner   req,
    output ic_pkg::data_t dram_word
);
    import ic_pkg::*;

    localparam int OFF_W = $clog2(LINE_BYTES);

    // Last accepted DRAM request
    logic [OFF_W-1:0] last_off;
    funct3_t          last_ctrl;

    line_t shifted;
    data_t raw;
    logic  sign_b;
    logic  sign_h;

    always_ff @(posedge CLK) begin
        if (reset) begin
            last_off  <= '0;
            last_ctrl <= '0;
        end else if (req.rd_en || req.wr_en) begin
            last_off  <= req.offset;
            last_ctrl <= req.ctrl;
        end
    end

    // Bring the addressed byte down to bit 0
    assign shifted = dram_rdata >> {last_off, 3'b000};
    assign raw     = shifted[31:0];

    // Sign bits, forced low for unsigned loads
    assign sign_b = raw[7] & ~last_ctrl[FUNCT3_UNSIGNED_BIT];
    assign sign_h = raw[15] & ~last_ctrl[FUNCT3_UNSIGNED_BIT];

    always_comb begin
        case (last_ctrl[1:0])
            LS_BYTE: begin
                dram_word = {{24{sign_b}}, raw[7:0]};
            end
            LS_HALF: begin
                dram_word = {{16{sign_h}}, raw[15:0]};
            end
            default: begin
                // Full word needs no extension
                dram_word = raw;
            end
        endcase
    end

endmodule

// File: verilog/mem_map_decode.sv
`timescale 1ns/100ps

module mem_map_decode (
    input  logic              CLK,
    input  logic              reset,
    input  ic_pkg::addr_t     cpu_addr,
    input  ic_pkg::data_t     cpu_wdata,
    input  ic_pkg::funct3_t   cpu_ctrl,
    input  logic              cpu_we,
    input  logic              cpu_re,
    input  logic              dram_busy,
    output ic_pkg::addr_t     dram_addr,
    output ic_pkg::data_t     dram_wdata,
    output ic_pkg::funct3_t   dram_ctrl,
    output logic              plic_we,
    output logic              plic_re,
    output logic              clint_we,
    output logic              fb_we,
    output ic_pkg::data_t     periph_wdata,
    output ic_pkg::resp_src_t resp_src,
    dram_req_if.decoder       req
);
    import ic_pkg::*;

    dev_t      dev;
    dev_t      virt;
    logic      is_dram;
    logic      dram_ok;
    logic      is_load;
    resp_src_t next_src;

    // Device and VirtIO sub-device fields
    assign dev  = cpu_addr[31:28];
    assign virt = cpu_addr[27:24];

    assign is_dram = (dev == DEV_DRAM_LOW) || (dev == DEV_DRAM_BASE);
    assign dram_ok = is_dram && !dram_busy;

    // A write wins when both strobes come in together
    assign is_load = cpu_re && !cpu_we;

    // DRAM request, dropped while the controller is busy
    assign req.wr_en = cpu_we && dram_ok;
    assign req.rd_en = is_load && dram_ok;
    assign req.addr  = cpu_addr;
    assign req.ctrl  = cpu_ctrl;

    assign dram_addr  = cpu_addr & DRAM_OFFSET_MASK;
    assign dram_wdata = cpu_wdata;
    assign dram_ctrl  = cpu_ctrl;

    // Peripheral strobes
    assign plic_we  = cpu_we && (dev == DEV_PLIC);
    assign plic_re  = cpu_re && (dev == DEV_PLIC);
    assign clint_we = cpu_we && (dev == DEV_CLINT);
    assign fb_we    = cpu_we && (dev == DEV_VIRTIO) && (virt == VIRT_FB);

    assign periph_wdata = cpu_wdata;

    // Source of next cycle's load data
    // Only loads return data, so writes and idle cycles give RESP_NONE
    always_comb begin
        next_src = RESP_NONE;
        if (is_load) begin
            if (dram_ok) begin
                next_src = RESP_DRAM;
            end else if (dev == DEV_PLIC) begin
                next_src = RESP_PLIC;
            end else if (dev == DEV_CLINT) begin
                next_src = RESP_CLINT;
            end else if ((dev == DEV_VIRTIO) && (virt == VIRT_FB)) begin
                next_src = RESP_FB;
            end
        end
    end

    // Registered device select, one cycle behind the request
    always_ff @(posedge CLK) begin
        if (reset) begin
            resp_src <= RESP_NONE;
        end else begin
            resp_src <= next_src;
        end
    end

endmodule

// File: verilog/read_return_mux.sv
`timescale 1ns/100ps

module read_return_mux (
    input  ic_pkg::resp_src_t resp_src,
    input  ic_pkg::data_t     dram_word,
    input  ic_pkg::data_t     plic_rdata,
    input  ic_pkg::data_t     clint_rdata,
    input  ic_pkg::data_t     fb_rdata,
    output ic_pkg::data_t     load_data,
    output logic              load_is_dram
);
    import ic_pkg::*;

    // Word returned to the CPU for last cycle's load
    always_comb begin
        case (resp_src)
            RESP_DRAM: begin
                load_data = dram_word;
            end
            RESP_PLIC: begin
                load_data = plic_rdata;
            end
            RESP_CLINT: begin
                load_data = clint_rdata;
            end
            RESP_FB: begin
                load_data = fb_rdata;
            end
            default: begin
                // Unmapped, idle or dropped access
                load_data = '0;
            end
        endcase
    end

    assign load_is_dram = (resp_src == RESP_DRAM);

endmodule
